// ==== hw/led_animator_top.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "led_config.svh"

module led_animator_top (
    input  wire                    sysclk,
    input  wire                    arst_n,
    input  wire                    cmd_wr,     // host strobe, no back-pressure
    input  wire led_pkg::led_cmd_t cmd,        // sampled with cmd_wr
    output logic [`LED_NUM-1:0]    led_drive
);

    import led_pkg::*;

    // enables from the prescaler, everything stays on sysclk
    wire pwm_tick;
    wire frame_start;
    wire step_adv;

    wire led_duty_t [`LED_NUM-1:0] duty_req;  // pattern unit -> pwm

    led_tick_gen i_tick (
        .sysclk      (sysclk),
        .arst_n      (arst_n),
        .pwm_tick    (pwm_tick),
        .frame_start (frame_start),
        .step_adv    (step_adv)
    );

    // channel state and duty rule
    led_pattern i_pattern (
        .sysclk   (sysclk),
        .arst_n   (arst_n),
        .cmd_wr   (cmd_wr),
        .cmd      (cmd),
        .step_adv (step_adv),
        .duty_req (duty_req)
    );

    // frame-latched compare, registered outputs
    led_pwm i_pwm (
        .sysclk      (sysclk),
        .arst_n      (arst_n),
        .pwm_tick    (pwm_tick),
        .frame_start (frame_start),
        .duty_req    (duty_req),
        .led_drive   (led_drive)
    );

endmodule

`default_nettype wire

// ==== hw/led_config.svh ====
`ifndef LED_CONFIG_SVH
`define LED_CONFIG_SVH

// channel count, one drive output each
`define LED_NUM 4

// pwm counter width, 64 counts per frame
`define PWM_BITS 6

// sysclk cycles per pwm count
`define TICK_DIV 2

// breathing pattern shape
`define SEG_LEN 8      // steps per segment
`define SEG_NUM 10     // segments per pattern
`define RAMP_INC 8     // duty change per step, SEG_LEN * RAMP_INC is full scale

// frames spent on one step before the index moves on
`define FRAMES_PER_STEP 2

// start index offset between neighbouring channels
`define PHASE_SPACING 20

`endif

// ==== hw/led_pattern.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "led_config.svh"

module led_pattern (
    input  wire                                 sysclk,
    input  wire                                 arst_n,
    input  wire                                 cmd_wr,    // one-cycle strobe
    input  wire led_pkg::led_cmd_t              cmd,
    input  wire                                 step_adv,
    output led_pkg::led_duty_t [`LED_NUM-1:0]   duty_req   // per channel, combinational
);

    import led_pkg::*;

    localparam int STEP_NUM = `SEG_LEN * `SEG_NUM;  // 80 steps per pattern
    localparam int DUTY_MAX = 1 << `PWM_BITS;       // always on

    led_chan_state_t [`LED_NUM-1:0] chan_q;

    // out-of-range phases fold back into the pattern
    function automatic led_step_t phase_load(input led_step_t ph);
        if (ph >= led_step_t'(STEP_NUM)) begin
            phase_load = ph - led_step_t'(STEP_NUM);
        end else begin
            phase_load = ph;
        end
    endfunction

    // duties above full scale saturate
    function automatic led_duty_t duty_load(input led_duty_t d);
        if (d > led_duty_t'(DUTY_MAX)) begin
            duty_load = led_duty_t'(DUTY_MAX);
        end else begin
            duty_load = d;
        end
    endfunction

    // segment rule, replaces the breathing lookup table
    function automatic led_duty_t seg_duty(input led_step_t idx);
        led_step_t seg;
        led_step_t k;
        seg = led_step_t'(idx / `SEG_LEN);
        k   = led_step_t'(idx % `SEG_LEN);
        case (seg)
            0, 4, 6: seg_duty = led_duty_t'((k + 1) * `RAMP_INC);            // ramp up
            1, 5, 7: seg_duty = led_duty_t'((`SEG_LEN - 1 - k) * `RAMP_INC); // ramp down
            default: seg_duty = '0;                                          // dark
        endcase
    endfunction

    always_ff @(posedge sysclk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < `LED_NUM; i++) begin
                chan_q[i].mode <= LED_MODE_PATTERN;
                chan_q[i].step <= led_step_t'(i * `PHASE_SPACING);  // staggered start
                chan_q[i].duty <= '0;
            end
        end else begin
            for (int i = 0; i < `LED_NUM; i++) begin
                if (cmd_wr && cmd.chan == led_chan_id_t'(i)) begin  // write beats step
                    chan_q[i].mode <= cmd.mode;
                    if (cmd.mode == LED_MODE_PATTERN) begin
                        chan_q[i].step <= phase_load(cmd.payload.phase);
                    end else begin
                        chan_q[i].duty <= duty_load(cmd.payload.duty);
                    end
                end else if (step_adv && chan_q[i].mode == LED_MODE_PATTERN) begin
                    if (chan_q[i].step == led_step_t'(STEP_NUM - 1)) begin
                        chan_q[i].step <= '0;  // 79 -> 0
                    end else begin
                        chan_q[i].step <= chan_q[i].step + 1'b1;
                    end
                end
            end
        end
    end

    // fixed duty or pattern value per channel
    always_comb begin
        for (int i = 0; i < `LED_NUM; i++) begin
            if (chan_q[i].mode == LED_MODE_FIXED) begin
                duty_req[i] = chan_q[i].duty;
            end else begin
                duty_req[i] = seg_duty(chan_q[i].step);
            end
        end
    end

endmodule

`default_nettype wire

// ==== hw/led_pkg.sv ====
`default_nettype none
`include "led_config.svh"

package led_pkg;

    // source of a channel's duty
    typedef enum logic {
        LED_MODE_PATTERN = 1'b0,  // stepped breathing pattern
        LED_MODE_FIXED   = 1'b1   // constant duty
    } led_mode_e;

    typedef logic [`PWM_BITS:0] led_duty_t;  // 0 .. full scale inclusive
    typedef logic [6:0]         led_step_t;  // pattern index, 0 .. 79
    typedef logic [1:0]         led_chan_id_t;

    // payload meaning depends on cmd mode
    typedef union packed {
        led_step_t phase;  // pattern mode, new start index
        led_duty_t duty;   // fixed mode, constant duty
    } led_payload_u;

    typedef struct packed {
        led_mode_e    mode;
        led_chan_id_t chan;
        led_payload_u payload;
    } led_cmd_t;

    // what each channel remembers between commands
    typedef struct packed {
        led_mode_e mode;
        led_step_t step;
        led_duty_t duty;  // only read in fixed mode
    } led_chan_state_t;

endpackage

`default_nettype wire

// ==== hw/led_pwm.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "led_config.svh"

module led_pwm (
    input  wire                                 sysclk,
    input  wire                                 arst_n,
    input  wire                                 pwm_tick,
    input  wire                                 frame_start,  // always on a tick
    input  wire led_pkg::led_duty_t [`LED_NUM-1:0] duty_req,
    output logic [`LED_NUM-1:0]                 led_drive
);

    import led_pkg::*;

    logic [`PWM_BITS-1:0]     pwm_cnt;   // shared by all channels
    logic [`PWM_BITS-1:0]     next_cnt;  // count after this tick
    led_duty_t [`LED_NUM-1:0] act_duty;  // held for a whole frame
    led_duty_t [`LED_NUM-1:0] duty_sel;  // duty seen by the compare

    assign next_cnt = pwm_cnt + 1'b1;  // 63 wraps to 0 on the frame tick

    // new duty takes effect on the frame's first count
    always_comb begin
        for (int i = 0; i < `LED_NUM; i++) begin
            duty_sel[i] = frame_start ? duty_req[i] : act_duty[i];
        end
    end

    always_ff @(posedge sysclk or negedge arst_n) begin
        if (!arst_n) begin
            pwm_cnt   <= '1;
            act_duty  <= '0;
            led_drive <= '0;
        end else if (pwm_tick) begin
            pwm_cnt <= next_cnt;
            if (frame_start) begin
                act_duty <= duty_req;  // mid-frame writes wait for this
            end
            for (int i = 0; i < `LED_NUM; i++) begin
                // duty 0 never high, full scale always high
                led_drive[i] <= (duty_sel[i] > {1'b0, next_cnt});
            end
        end
    end

endmodule

`default_nettype wire

// ==== hw/led_tick_gen.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "led_config.svh"

module led_tick_gen (
    input  wire  sysclk,
    input  wire  arst_n,
    output logic pwm_tick,     // one pwm count per pulse
    output logic frame_start,  // first tick of a pwm frame
    output logic step_adv      // pattern index advance
);

    // keep widths at least one bit for divide-by-one settings
    localparam int PRE_W = (`TICK_DIV > 1) ? $clog2(`TICK_DIV) : 1;
    localparam int FRM_W = (`FRAMES_PER_STEP > 1) ? $clog2(`FRAMES_PER_STEP) : 1;

    logic [PRE_W-1:0]     pre_q;  // sysclk prescaler
    logic [`PWM_BITS-1:0] cnt_q;  // mirrors the pwm counter
    logic [FRM_W-1:0]     frm_q;  // frames into current step

    // all three strobes come straight off the counters, same cycle
    assign pwm_tick    = (pre_q == PRE_W'(`TICK_DIV - 1));
    assign frame_start = pwm_tick && (cnt_q == '1);  // 63 -> 0 wrap
    assign step_adv    = frame_start && (frm_q == FRM_W'(`FRAMES_PER_STEP - 1));

    always_ff @(posedge sysclk or negedge arst_n) begin
        if (!arst_n) begin
            pre_q <= '0;
            cnt_q <= '1;  // first tick wraps, so it opens a frame
            frm_q <= '0;
        end else begin
            if (pwm_tick) begin
                pre_q <= '0;
            end else begin
                pre_q <= pre_q + 1'b1;
            end

            if (pwm_tick) begin
                cnt_q <= cnt_q + 1'b1;  // power of two, wraps by itself
            end

            if (frame_start) begin
                if (step_adv) begin
                    frm_q <= '0;
                end else begin
                    frm_q <= frm_q + 1'b1;
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the led animator testbench with verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module tb_led_animator -f sim.f -o sim_led_animator \
    || { echo "verilator build failed"; exit 1; }

out=$(./obj_dir/sim_led_animator)
echo "$out"
echo "$out" | grep -qx "sim passed" && exit 0 || exit 1

// ==== sim.f ====
+incdir+hw
hw/led_pkg.sv
hw/led_tick_gen.sv
hw/led_pattern.sv
hw/led_pwm.sv
hw/led_animator_top.sv
sim/led_checker.sv
sim/led_animator_asserts.sv
sim/tb_led_animator.sv

// ==== sim/led_animator_asserts.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "led_config.svh"

module led_animator_asserts #(
    parameter bit PWM_SIDE = 1'b1  // 1 on the pwm side, 0 on the pattern side
) (
    input wire                                       sysclk,
    input wire                                       arst_n,
    input wire                                       pwm_tick,
    input wire [`LED_NUM-1:0]                        led_drive,
    input wire led_pkg::led_duty_t [`LED_NUM-1:0]    duty,  // active or requested duty
    input wire led_pkg::led_chan_state_t [`LED_NUM-1:0] chan
);

    import led_pkg::*;

    // outputs only move on the edge right after a tick
    if (PWM_SIDE) begin : g_drive
        drive_after_tick: assert property (@(posedge sysclk) disable iff (!arst_n)
            (led_drive != $past(led_drive)) |-> $past(pwm_tick))
            else $error("led_drive changed without a pwm_tick the cycle before");
    end

    for (genvar i = 0; i < `LED_NUM; i++) begin : g_chan
        duty_in_range: assert property (@(posedge sysclk) disable iff (!arst_n)
            duty[i] <= led_duty_t'(1 << `PWM_BITS))
            else $error("duty of channel %0d above full scale", i);
        // step registers only live in the pattern unit
        if (!PWM_SIDE) begin : g_step
            step_in_range: assert property (@(posedge sysclk) disable iff (!arst_n)
                chan[i].step < led_step_t'(`SEG_LEN * `SEG_NUM))
                else $error("step index of channel %0d past the last segment", i);
        end
    end

endmodule

// pwm side, no channel state here
bind led_pwm led_animator_asserts #(.PWM_SIDE(1'b1)) i_asserts (
    .sysclk    (sysclk),
    .arst_n    (arst_n),
    .pwm_tick  (pwm_tick),
    .led_drive (led_drive),
    .duty      (act_duty),
    .chan      ('0)
);

// pattern side, requested duties and step registers
bind led_pattern led_animator_asserts #(.PWM_SIDE(1'b0)) i_asserts (
    .sysclk    (sysclk),
    .arst_n    (arst_n),
    .pwm_tick  (1'b1),
    .led_drive ('0),
    .duty      (duty_req),
    .chan      (chan_q)
);

`default_nettype wire

// ==== sim/led_checker.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "led_config.svh"

module led_checker (
    input  wire                    sysclk,
    input  wire                    arst_n,
    input  wire                    cmd_wr,
    input  wire led_pkg::led_cmd_t cmd,
    input  wire [`LED_NUM-1:0]     led_drive,
    input  wire                    run_done,     // stimulus and idle time over
    input  wire                    timeout_hit,
    output logic                   report_done,
    output logic [31:0]            err_total
);

    import led_pkg::*;

    localparam int FRAME_LEN = 1 << `PWM_BITS;          // counts per frame
    localparam int STEP_NUM  = `SEG_LEN * `SEG_NUM;

    // model state, updated on the same edges as the DUT
    int                 pre;
    int                 cnt;
    int                 frm;
    bit                 m_fixed [`LED_NUM];
    int                 m_step  [`LED_NUM];
    int                 m_fduty [`LED_NUM];
    int                 m_act   [`LED_NUM];
    logic [`LED_NUM-1:0] m_drive;

    int unsigned checks     = 0;
    int unsigned mismatches = 0;
    bit          done_q     = 1'b0;
    int unsigned err_q      = 0;

    assign report_done = done_q;
    assign err_total   = err_q;

    // breathing shape: up, down, off, off, up, down, up, down, off, off
    function automatic int pattern_duty(input int idx);
        int seg;
        int k;
        seg = idx / `SEG_LEN;
        k   = idx % `SEG_LEN;
        if (seg == 0 || seg == 4 || seg == 6) return (k + 1) * `RAMP_INC;
        if (seg == 1 || seg == 5 || seg == 7) return (`SEG_LEN - 1 - k) * `RAMP_INC;
        return 0;
    endfunction

    always @(posedge sysclk or negedge arst_n) begin
        int req [`LED_NUM];
        bit tick;
        bit fs;
        bit sa;
        int nxt;
        if (!arst_n) begin
            pre     = 0;
            cnt     = FRAME_LEN - 1;  // first tick opens a frame
            frm     = 0;
            m_drive = '0;
            for (int i = 0; i < `LED_NUM; i++) begin
                m_fixed[i] = 1'b0;
                m_step[i]  = i * `PHASE_SPACING;
                m_fduty[i] = 0;
                m_act[i]   = 0;
            end
        end else begin
            tick = (pre == `TICK_DIV - 1);
            fs   = tick && (cnt == FRAME_LEN - 1);
            sa   = fs && (frm == `FRAMES_PER_STEP - 1);
            for (int i = 0; i < `LED_NUM; i++) begin
                req[i] = m_fixed[i] ? m_fduty[i] : pattern_duty(m_step[i]);
            end
            if (tick) begin
                nxt = (cnt + 1) % FRAME_LEN;
                for (int i = 0; i < `LED_NUM; i++) begin
                    if (fs) m_act[i] = req[i];     // duty held for the frame
                    m_drive[i] = (m_act[i] > nxt);
                end
                cnt = nxt;
            end
            pre = tick ? 0 : pre + 1;
            if (fs) frm = sa ? 0 : frm + 1;
            for (int i = 0; i < `LED_NUM; i++) begin
                if (cmd_wr && int'(cmd.chan) == i) begin  // write wins over step
                    m_fixed[i] = (cmd.mode == LED_MODE_FIXED);
                    if (cmd.mode == LED_MODE_FIXED) m_fduty[i] = int'(cmd.payload.duty);
                    else m_step[i] = int'(cmd.payload.phase);
                end else if (sa && !m_fixed[i]) begin
                    m_step[i] = (m_step[i] + 1) % STEP_NUM;
                end
            end
        end
    end

    // outputs settled half a cycle after the edge
    always @(negedge sysclk) begin
        if (!done_q) begin
            checks <= checks + 1;
            for (int i = 0; i < `LED_NUM; i++) begin
                if (led_drive[i] !== m_drive[i]) begin
                    mismatches = mismatches + 1;
                    $display("FAILED led_drive[%0d] cycle %0d expected %h actual %h",
                             i, checks, m_drive[i], led_drive[i]);
                end
            end
            if (run_done || timeout_hit) begin
                err_q = mismatches + (timeout_hit ? 1 : 0);
                $display("checks %0d, drive mismatches %0d, timeouts %0d, errors %0d",
                         checks, mismatches, timeout_hit ? 1 : 0, err_q);
                done_q = 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// ==== sim/tb_led_animator.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "led_config.svh"

module tb_led_animator;

    import led_pkg::*;

    localparam int NUM_CMDS       = 40;
    localparam int MIN_GAP        = 100;
    localparam int MAX_GAP        = 400;
    localparam int IDLE_CYCLES    = 2000;
    localparam int RESET_CYCLES   = 3;
    localparam int TIMEOUT_CYCLES = NUM_CMDS * MAX_GAP + IDLE_CYCLES + RESET_CYCLES + 1997;

    logic               sysclk = 1'b0;
    logic               arst_n;
    logic               cmd_wr;
    led_cmd_t           cmd;
    wire [`LED_NUM-1:0] led_drive;
    logic               run_done;
    logic               timeout_hit = 1'b0;
    wire                report_done;
    wire [31:0]         err_total;
    int                 cycle_cnt = 0;

    always #5 sysclk = ~sysclk;  // 10 ns period

    led_animator_top i_led_animator_top (
        .sysclk    (sysclk),
        .arst_n    (arst_n),
        .cmd_wr    (cmd_wr),
        .cmd       (cmd),
        .led_drive (led_drive)
    );

    // reference model and compare, sees the DUT ports only
    led_checker i_checker (
        .sysclk      (sysclk),
        .arst_n      (arst_n),
        .cmd_wr      (cmd_wr),
        .cmd         (cmd),
        .led_drive   (led_drive),
        .run_done    (run_done),
        .timeout_hit (timeout_hit),
        .report_done (report_done),
        .err_total   (err_total)
    );

    // mostly anywhere in range, now and then the extremes
    function automatic led_duty_t pick_duty();
        int unsigned r;
        r = $urandom % 8;
        if (r == 0) return '0;                              // always dark
        if (r == 1) return led_duty_t'(1 << `PWM_BITS);     // always lit
        return led_duty_t'($urandom % ((1 << `PWM_BITS) + 1));
    endfunction

    // a quarter of the phases land just before the 79 -> 0 wrap
    function automatic led_step_t pick_phase();
        if ($urandom % 4 == 0) return led_step_t'(72 + $urandom % 8);
        return led_step_t'($urandom % (`SEG_LEN * `SEG_NUM));
    endfunction

    function automatic led_cmd_t make_cmd();
        led_cmd_t c;
        c.chan = led_chan_id_t'($urandom % `LED_NUM);
        if ($urandom % 2 == 0) begin
            c.mode         = LED_MODE_FIXED;
            c.payload.duty = pick_duty();
        end else begin
            c.mode          = LED_MODE_PATTERN;
            c.payload.phase = pick_phase();
        end
        return c;
    endfunction

    // one-cycle strobe, driven just after the edge
    task automatic send_cmd(input led_cmd_t c);
        #1;
        cmd_wr = 1'b1;
        cmd    = c;
        @(posedge sysclk);
        #1;
        cmd_wr = 1'b0;
    endtask

    initial begin
        int unsigned gap;
        void'($urandom(32'h8b74_b5af));
        arst_n   = 1'b0;
        cmd_wr   = 1'b0;
        cmd      = '0;
        run_done = 1'b0;
        repeat (RESET_CYCLES) @(posedge sysclk);
        #1 arst_n = 1'b1;
        for (int n = 0; n < NUM_CMDS; n++) begin
            gap = MIN_GAP + $urandom % (MAX_GAP - MIN_GAP + 1);
            repeat (gap) @(posedge sysclk);  // lands anywhere in a frame
            send_cmd(make_cmd());
        end
        repeat (IDLE_CYCLES) @(posedge sysclk);
        run_done = 1'b1;
    end

    always @(posedge sysclk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt == TIMEOUT_CYCLES && !run_done) begin
            $display("timeout reached before stimulus finished");
            timeout_hit <= 1'b1;
        end
    end

    initial begin
        wait (report_done);
        #1;
        if (err_total == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
